// File: lsq_defs.svh
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// Entries per queue as a power of two
`define LSQ_DEPTH 8

// Physical register tag width
`define LSQ_TAG_W 6

// Data and address width
`define LSQ_XLEN 32

`endif

// File: lsq_pkg.sv
`include "lsq_defs.svh"

package lsq_pkg;

    typedef logic [$clog2(`LSQ_DEPTH)-1:0] lsq_ptr_t;
    typedef logic [`LSQ_TAG_W-1:0] preg_t;
    typedef logic [`LSQ_XLEN-1:0] word_t;

    typedef enum logic [1:0] {
        mem_byte,
        mem_half,
        mem_word
    } mem_size_e;

    typedef enum logic [2:0] {
        idle_load_first,
        idle_store_first,
        bus_load,
        bus_store,
        done_load,
        done_store
    } issue_state_e;

    // Tag 0 is x0 and never waits for a broadcast
    typedef struct packed {
        logic      is_store;
        mem_size_e size;
        logic      is_signed;
        preg_t     rs1;
        preg_t     rs2;
        preg_t     rd;
        word_t     imm;
    } mem_op_t;

    typedef struct packed {
        mem_op_t  op;
        logic     rs1_ready;
        logic     rs2_ready;
        lsq_ptr_t cross_ptr;
        logic     older_done;
    } lsq_entry_t;

    typedef struct packed {
        logic  valid;
        preg_t tag;
        word_t value;
        logic  is_store;
    } cdb_t;

    typedef struct packed {
        preg_t rs1;
        preg_t rs2;
    } reg_req_t;

    typedef struct packed {
        word_t rs1_val;
        word_t rs2_val;
    } reg_rsp_t;

endpackage

// File: lsq_entry_queue.sv
`include "lsq_defs.svh"

module lsq_entry_queue (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               push,
    input  lsq_pkg::mem_op_t   push_op,
    input  lsq_pkg::lsq_ptr_t  other_wr_ptr,
    input  lsq_pkg::lsq_ptr_t  other_rd_ptr,
    input  lsq_pkg::cdb_t      cdb_in,
    input  logic               pop,
    output logic               full,
    output lsq_pkg::lsq_ptr_t  wr_ptr,
    output lsq_pkg::lsq_ptr_t  rd_ptr,
    output lsq_pkg::lsq_entry_t head,
    output logic               head_ready
);
    import lsq_pkg::*;

    localparam int ptr_w = $bits(lsq_ptr_t);

    lsq_entry_t mem_q [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0] valid_q;
    logic [`LSQ_DEPTH-1:0] cross_wrap_q;
    logic [ptr_w:0] wr_q;
    logic [ptr_w:0] rd_q;
    logic empty;
    logic do_push;
    logic do_pop;
    logic flushed_q;
    lsq_entry_t new_entry;

    // Mirror of the other queue's occupancy, seen through its pointers
    lsq_ptr_t prev_wr_q;
    lsq_ptr_t prev_rd_q;
    logic grew_q;
    logic other_grew;
    logic other_full;

    function automatic logic wakes(cdb_t c, preg_t t);
        return c.valid && !c.is_store && c.tag == t;
    endfunction

    assign wr_ptr = wr_q[ptr_w-1:0];
    assign rd_ptr = rd_q[ptr_w-1:0];
    assign empty = wr_q == rd_q;
    assign full = (wr_q[ptr_w] != rd_q[ptr_w]) && (wr_ptr == rd_ptr);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_comb begin
        other_grew = grew_q;
        if (other_wr_ptr != prev_wr_q && other_rd_ptr == prev_rd_q)
            other_grew = 1'b1;
        else if (other_rd_ptr != prev_rd_q && other_wr_ptr == prev_wr_q)
            other_grew = 1'b0;
    end

    // Equal pointers mean empty unless the last change was a push
    assign other_full = (other_wr_ptr == other_rd_ptr) && other_grew;

    always_comb begin
        new_entry.op = push_op;
        new_entry.rs1_ready = push_op.rs1 == '0 || wakes(cdb_in, push_op.rs1);
        new_entry.rs2_ready = !push_op.is_store || push_op.rs2 == '0
                              || wakes(cdb_in, push_op.rs2);
        new_entry.cross_ptr = other_wr_ptr;
        new_entry.older_done = (other_wr_ptr == other_rd_ptr) && !other_full;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_q <= '0;
            rd_q <= '0;
            valid_q <= '0;
            prev_wr_q <= '0;
            prev_rd_q <= '0;
            grew_q <= 1'b0;
            flushed_q <= flush && !rst;
        end else begin
            prev_wr_q <= other_wr_ptr;
            prev_rd_q <= other_rd_ptr;
            grew_q <= other_grew;
            if (do_push) begin
                wr_q <= wr_q + 1'b1;
                valid_q[wr_ptr] <= 1'b1;
                flushed_q <= 1'b0;
            end
            if (do_pop) begin
                rd_q <= rd_q + 1'b1;
                valid_q[rd_ptr] <= 1'b0;
            end
        end
    end

    // Wake-up and cross dependency tracking in place
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (do_push && lsq_ptr_t'(i) == wr_ptr) begin
                mem_q[i] <= new_entry;
                cross_wrap_q[i] <= other_full;
            end else if (valid_q[i]) begin
                if (wakes(cdb_in, mem_q[i].op.rs1))
                    mem_q[i].rs1_ready <= 1'b1;
                if (wakes(cdb_in, mem_q[i].op.rs2))
                    mem_q[i].rs2_ready <= 1'b1;
                // Full at push, so wait for the read pointer to lap once
                if (other_rd_ptr != mem_q[i].cross_ptr)
                    cross_wrap_q[i] <= 1'b0;
                else if (!cross_wrap_q[i])
                    mem_q[i].older_done <= 1'b1;
            end
        end
    end

    assign head = mem_q[rd_ptr];
    assign head_ready = valid_q[rd_ptr] && head.rs1_ready && head.rs2_ready
                        && head.older_done;

    assert property (@(posedge clk) disable iff (rst) push |-> !full);

    // A late ack from before a flush may find the queue empty
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty || flushed_q);

endmodule

// File: lsq_load_align.sv
module lsq_load_align (
    input  lsq_pkg::word_t     rdata,
    input  logic [1:0]         byte_off,
    input  lsq_pkg::mem_size_e size,
    input  logic               is_signed,
    output lsq_pkg::word_t     value
);
    import lsq_pkg::*;

    word_t shifted;
    logic fill;

    // Addressed lane moves down to bit 0
    assign shifted = rdata >> {byte_off, 3'b000};

    always_comb begin
        case (size)
            mem_byte: begin
                fill = is_signed && shifted[7];
                value = {{24{fill}}, shifted[7:0]};
            end
            mem_half: begin
                fill = is_signed && shifted[15];
                value = {{16{fill}}, shifted[15:0]};
            end
            default: begin
                fill = 1'b0;
                value = shifted;
            end
        endcase
    end

endmodule

// File: lsq_issue_ctrl.sv
module lsq_issue_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  lsq_pkg::lsq_entry_t ld_head,
    input  lsq_pkg::lsq_entry_t st_head,
    input  logic                ld_ready,
    input  logic                st_ready,
    output logic                ld_pop,
    output logic                st_pop,
    output lsq_pkg::reg_req_t   reg_req,
    input  lsq_pkg::reg_rsp_t   reg_rsp,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output lsq_pkg::word_t      wb_adr,
    output logic [3:0]          wb_sel,
    output lsq_pkg::word_t      wb_dat_o,
    input  lsq_pkg::word_t      wb_dat_i,
    input  logic                wb_ack,
    input  lsq_pkg::word_t      load_value,
    output logic [1:0]          load_off,
    output lsq_pkg::mem_size_e  load_size,
    output logic                load_signed,
    output lsq_pkg::word_t      load_rdata,
    output lsq_pkg::cdb_t       cdb_out
);
    import lsq_pkg::*;

    issue_state_e state;
    issue_state_e state_next;
    logic idle;
    logic pick_load;
    logic pick_store;
    mem_op_t sel_op;
    word_t addr;
    logic [3:0] size_mask;
    preg_t rd_q;

    // Priority alternates after each completed access
    assign idle = (state == idle_load_first) || (state == idle_store_first);
    assign pick_load = idle && ld_ready && (state == idle_load_first || !st_ready);
    assign pick_store = idle && st_ready && (state == idle_store_first || !ld_ready);
    assign sel_op = pick_store ? st_head.op : ld_head.op;

    // Register file answers in the issue cycle
    assign reg_req.rs1 = sel_op.rs1;
    assign reg_req.rs2 = sel_op.rs2;
    assign addr = reg_rsp.rs1_val + sel_op.imm;

    always_comb begin
        case (sel_op.size)
            mem_byte: size_mask = 4'b0001;
            mem_half: size_mask = 4'b0011;
            default:  size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            idle_load_first, idle_store_first: begin
                if (pick_load)
                    state_next = bus_load;
                else if (pick_store)
                    state_next = bus_store;
            end
            bus_load: begin
                if (wb_ack)
                    state_next = done_load;
            end
            bus_store: begin
                if (wb_ack)
                    state_next = done_store;
            end
            done_load:  state_next = idle_store_first;
            done_store: state_next = idle_load_first;
            default:    state_next = idle_load_first;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= idle_load_first;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (pick_load || pick_store) begin
            wb_adr <= {addr[31:2], 2'b00};
            wb_sel <= size_mask << addr[1:0];
            wb_dat_o <= reg_rsp.rs2_val << {addr[1:0], 3'b000};
            wb_we <= pick_store;
            load_off <= addr[1:0];
            load_size <= sel_op.size;
            load_signed <= sel_op.is_signed;
            rd_q <= sel_op.rd;
        end
        if (wb_cyc && wb_ack)
            load_rdata <= wb_dat_i;
    end

    assign wb_cyc = (state == bus_load) || (state == bus_store);
    assign wb_stb = wb_cyc;
    assign ld_pop = (state == bus_load) && wb_ack;
    assign st_pop = (state == bus_store) && wb_ack;

    // One result per access and never stalled
    always_comb begin
        cdb_out.valid = (state == done_load) || (state == done_store);
        cdb_out.tag = rd_q;
        cdb_out.value = (state == done_load) ? load_value : '0;
        cdb_out.is_store = state == done_store;
    end

    // Bus request held steady until acknowledged
    assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_sel)
                              && $stable(wb_we) && $stable(wb_dat_o));

    assert property (@(posedge clk) disable iff (rst)
        cdb_out.valid |-> $past(wb_cyc && wb_ack));

endmodule

// File: load_store_unit.sv
module load_store_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              op_valid,
    input  lsq_pkg::mem_op_t  op,
    output logic              op_ready,
    input  lsq_pkg::cdb_t     cdb_in,
    output lsq_pkg::reg_req_t reg_req,
    input  lsq_pkg::reg_rsp_t reg_rsp,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output lsq_pkg::word_t    wb_adr,
    output logic [3:0]        wb_sel,
    output lsq_pkg::word_t    wb_dat_o,
    input  lsq_pkg::word_t    wb_dat_i,
    input  logic              wb_ack,
    output lsq_pkg::cdb_t     cdb_out
);
    import lsq_pkg::*;

    logic ld_push;
    logic st_push;
    logic ld_full;
    logic st_full;
    logic ld_pop;
    logic st_pop;
    logic ld_ready;
    logic st_ready;
    lsq_ptr_t ld_wr_ptr;
    lsq_ptr_t ld_rd_ptr;
    lsq_ptr_t st_wr_ptr;
    lsq_ptr_t st_rd_ptr;
    lsq_entry_t ld_head;
    lsq_entry_t st_head;
    word_t load_value;
    word_t load_rdata;
    logic [1:0] load_off;
    mem_size_e load_size;
    logic load_signed;

    assign op_ready = op.is_store ? !st_full : !ld_full;
    assign ld_push = op_valid && op_ready && !op.is_store;
    assign st_push = op_valid && op_ready && op.is_store;

    lsq_entry_queue load_queue (
        .clk(clk), .rst(rst), .flush(flush),
        .push(ld_push), .push_op(op),
        .other_wr_ptr(st_wr_ptr), .other_rd_ptr(st_rd_ptr),
        .cdb_in(cdb_in), .pop(ld_pop), .full(ld_full),
        .wr_ptr(ld_wr_ptr), .rd_ptr(ld_rd_ptr),
        .head(ld_head), .head_ready(ld_ready)
    );

    lsq_entry_queue store_queue (
        .clk(clk), .rst(rst), .flush(flush),
        .push(st_push), .push_op(op),
        .other_wr_ptr(ld_wr_ptr), .other_rd_ptr(ld_rd_ptr),
        .cdb_in(cdb_in), .pop(st_pop), .full(st_full),
        .wr_ptr(st_wr_ptr), .rd_ptr(st_rd_ptr),
        .head(st_head), .head_ready(st_ready)
    );

    lsq_issue_ctrl issue_ctrl (
        .clk(clk), .rst(rst),
        .ld_head(ld_head), .st_head(st_head),
        .ld_ready(ld_ready), .st_ready(st_ready),
        .ld_pop(ld_pop), .st_pop(st_pop),
        .reg_req(reg_req), .reg_rsp(reg_rsp),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_o(wb_dat_o),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .load_value(load_value), .load_off(load_off),
        .load_size(load_size), .load_signed(load_signed),
        .load_rdata(load_rdata), .cdb_out(cdb_out)
    );

    lsq_load_align load_align (
        .rdata(load_rdata),
        .byte_off(load_off),
        .size(load_size),
        .is_signed(load_signed),
        .value(load_value)
    );

endmodule

// File: lsu_checker.sv
`include "lsq_defs.svh"

module lsu_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              op_valid,
    input  lsq_pkg::mem_op_t  op,
    input  logic              op_ready,
    input  lsq_pkg::cdb_t     cdb_in,
    input  lsq_pkg::reg_req_t reg_req,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  lsq_pkg::word_t    wb_adr,
    input  logic [3:0]        wb_sel,
    input  lsq_pkg::word_t    wb_dat_o,
    input  logic              wb_ack,
    input  lsq_pkg::cdb_t     cdb_out,
    input  logic [7:0][31:0]  reg_vals,
    input  logic              report,
    output int                errors,
    output int                results
);
    import lsq_pkg::*;

    word_t mem [16];
    mem_op_t op_q [$];
    logic [1:0] woke_q [$];
    logic stb_q = 1'b0;
    logic ack_q = 1'b0;
    logic we_q;
    logic [3:0] sel_q;
    word_t adr_q;
    word_t dat_q;
    reg_req_t req_q;
    word_t exp_value;
    int ld_cnt = 0;
    int st_cnt = 0;
    int err_cnt = 0;
    int res_cnt = 0;
    int bus_cycles = 0;

    assign errors = err_cnt;
    assign results = res_cnt;

    function automatic word_t fill_word(int i);
        return (32'h9e37_79b9 * (i + 1)) ^ (i << 28);
    endfunction

    function automatic logic [3:0] size_lanes(mem_size_e s);
        case (s)
            mem_byte: return 4'b0001;
            mem_half: return 4'b0011;
            default:  return 4'b1111;
        endcase
    endfunction

    function automatic word_t extend_load(word_t w, logic [1:0] off, mem_op_t o);
        logic [7:0] b;
        logic [15:0] hw;
        b = w[8*off +: 8];
        hw = w[16*off[1] +: 16];
        case (o.size)
            mem_byte: return o.is_signed ? {{24{b[7]}}, b} : {24'h0, b};
            mem_half: return o.is_signed ? {{16{hw[15]}}, hw} : {16'h0, hw};
            default:  return w;
        endcase
    endfunction

    // Bit 0 for rs1, bit 1 for rs2
    function automatic logic [1:0] woken_by_cdb(mem_op_t o, cdb_t c);
        if (!c.valid || c.is_store)
            return 2'b00;
        return {o.rs2 == c.tag, o.rs1 == c.tag};
    endfunction

    task automatic report_mismatch(string name, word_t got, word_t exp);
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        err_cnt++;
    endtask

    task automatic report_failure(string what);
        $display("At %0t: %s", $time, what);
        err_cnt++;
    endtask

    // Sampled mid-cycle, where every DUT output has settled
    always @(negedge clk) begin : sample
        mem_op_t h;
        word_t a;
        word_t sdata;
        logic [3:0] lanes;
        logic has_op;
        logic exp_ready;
        has_op = op_q.size() > 0;
        if (has_op) begin
            h = op_q[0];
            a = reg_vals[h.rs1[2:0]] + h.imm;
            lanes = size_lanes(h.size) << a[1:0];
            sdata = reg_vals[h.rs2[2:0]] << (8 * a[1:0]);
        end
        if (rst || flush) begin
            if (rst) begin
                for (int i = 0; i < 16; i++)
                    mem[i] = fill_word(i);
            end
            op_q.delete();
            woke_q.delete();
            ld_cnt = 0;
            st_cnt = 0;
            stb_q = 1'b0;
            ack_q = 1'b0;
        end else begin
            if (wb_stb && !wb_cyc)
                report_failure("wb_stb is high while wb_cyc is low");
            if (!has_op && (wb_cyc || cdb_out.valid))
                report_failure("Bus cycle or result appeared with no op outstanding");
            if (!has_op && !op_ready)
                report_failure("op_ready is low although both queues are empty");
            // A queue holds an entry from its push until the ack of its access
            exp_ready = op.is_store ? (st_cnt < `LSQ_DEPTH) : (ld_cnt < `LSQ_DEPTH);
            if (op_valid && op_ready !== exp_ready)
                report_mismatch("op_ready", word_t'(op_ready), word_t'(exp_ready));
            // Request must hold until acknowledged
            if (stb_q && !ack_q) begin
                if (!wb_stb)
                    report_failure("wb_stb dropped before wb_ack");
                if (wb_adr !== adr_q)
                    report_mismatch("wb_adr", wb_adr, adr_q);
                if (wb_sel !== sel_q)
                    report_mismatch("wb_sel", word_t'(wb_sel), word_t'(sel_q));
                if (wb_we !== we_q)
                    report_mismatch("wb_we", word_t'(wb_we), word_t'(we_q));
                if (we_q && wb_dat_o !== dat_q)
                    report_mismatch("wb_dat_o", wb_dat_o, dat_q);
            end
            if (wb_stb && !stb_q && has_op) begin
                bus_cycles++;
                if (!woke_q[0][0] || (h.is_store && !woke_q[0][1]))
                    report_failure("Bus cycle started before the operand tags were broadcast");
                // Operand read happens in the cycle before the request
                if (req_q.rs1 !== h.rs1)
                    report_mismatch("reg_req.rs1", word_t'(req_q.rs1), word_t'(h.rs1));
                if (req_q.rs2 !== h.rs2)
                    report_mismatch("reg_req.rs2", word_t'(req_q.rs2), word_t'(h.rs2));
                if (wb_we !== h.is_store)
                    report_mismatch("wb_we", word_t'(wb_we), word_t'(h.is_store));
                if (wb_adr !== {a[31:2], 2'b00})
                    report_mismatch("wb_adr", wb_adr, {a[31:2], 2'b00});
                if (wb_sel !== lanes)
                    report_mismatch("wb_sel", word_t'(wb_sel), word_t'(lanes));
                if (h.is_store && wb_dat_o !== sdata)
                    report_mismatch("wb_dat_o", wb_dat_o, sdata);
            end
            if (wb_stb && wb_ack && has_op) begin
                if (h.is_store) begin
                    for (int k = 0; k < 4; k++) begin
                        if (lanes[k])
                            mem[a[5:2]][8*k +: 8] = sdata[8*k +: 8];
                    end
                    exp_value = '0;
                    st_cnt--;
                end else begin
                    exp_value = extend_load(mem[a[5:2]], a[1:0], h);
                    ld_cnt--;
                end
            end
            if (cdb_out.valid !== ack_q)
                report_mismatch("cdb_out.valid", word_t'(cdb_out.valid), word_t'(ack_q));
            if (cdb_out.valid && has_op) begin
                op_q.delete(0);
                woke_q.delete(0);
                res_cnt++;
                if (cdb_out.tag !== h.rd)
                    report_mismatch("cdb_out.tag", word_t'(cdb_out.tag), word_t'(h.rd));
                if (cdb_out.is_store !== h.is_store)
                    report_mismatch("cdb_out.is_store", word_t'(cdb_out.is_store),
                                    word_t'(h.is_store));
                if (cdb_out.value !== exp_value)
                    report_mismatch("cdb_out.value", cdb_out.value, exp_value);
            end
            for (int i = 0; i < op_q.size(); i++)
                woke_q[i] = woke_q[i] | woken_by_cdb(op_q[i], cdb_in);
            if (op_valid && op_ready) begin
                op_q.push_back(op);
                woke_q.push_back({op.rs2 == '0, op.rs1 == '0} | woken_by_cdb(op, cdb_in));
                if (op.is_store)
                    st_cnt++;
                else
                    ld_cnt++;
            end
            stb_q = wb_stb;
            ack_q = wb_stb && wb_ack;
            adr_q = wb_adr;
            sel_q = wb_sel;
            we_q = wb_we;
            dat_q = wb_dat_o;
            req_q = reg_req;
        end
    end

    always @(posedge report)
        $display("lsu_checker: %0d results, %0d bus cycles, %0d errors",
                 res_cnt, bus_cycles, err_cnt);

endmodule

// File: tb_load_store_unit.sv
module tb_load_store_unit;
    import lsq_pkg::*;

    localparam int clk_period = 8;
    localparam int num_ops = 300;
    localparam int timeout = num_ops * 12 * clk_period + 200 * clk_period;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic op_valid;
    mem_op_t op;
    logic op_ready;
    cdb_t cdb_in = '0;
    reg_req_t reg_req;
    reg_rsp_t reg_rsp;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    word_t wb_adr;
    logic [3:0] wb_sel;
    word_t wb_dat_o;
    word_t wb_dat_i = '0;
    logic wb_ack = 1'b0;
    cdb_t cdb_out;

    logic [7:0][31:0] reg_vals;
    word_t mem [16];
    logic [15:0] lfsr = 16'd5819;
    int cycle_cnt = 0;
    int dispatched = 0;
    int waits = -1;
    int errors;
    int results;
    logic report = 1'b0;
    preg_t wake_tag [$];
    int wake_due [$];

    load_store_unit uut (.*);
    lsu_checker chk (.*);

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // Register file answers straight from the tag table
    assign reg_rsp = {reg_vals[reg_req.rs1[2:0]], reg_vals[reg_req.rs2[2:0]]};

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t fill_word(int i);
        return (32'h9e37_79b9 * (i + 1)) ^ (i << 28);
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Wishbone memory with 0 to 3 wait states
    always @(posedge clk) begin : wb_memory
        #1;
        if (rst) begin
            for (int i = 0; i < 16; i++)
                mem[i] = fill_word(i);
            wb_ack = 1'b0;
            waits = -1;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
            waits = -1;
        end else if (wb_cyc && wb_stb) begin
            if (waits < 0)
                waits = rand_bits(2);
            if (waits == 0) begin
                wb_dat_i = mem[wb_adr[5:2]];
                for (int k = 0; k < 4; k++) begin
                    if (wb_we && wb_sel[k])
                        mem[wb_adr[5:2]][8*k +: 8] = wb_dat_o[8*k +: 8];
                end
                wb_ack = 1'b1;
            end else begin
                waits--;
            end
        end
    end

    // Delayed operand broadcasts at most once per cycle
    always @(posedge clk) begin : wake_bus
        logic sent;
        #1;
        sent = 1'b0;
        cdb_in = '0;
        for (int i = 0; i < wake_tag.size() && !sent; i++) begin
            if (wake_due[i] <= cycle_cnt) begin
                cdb_in.valid = 1'b1;
                cdb_in.tag = wake_tag[i];
                cdb_in.value = reg_vals[wake_tag[i][2:0]];
                wake_tag.delete(i);
                wake_due.delete(i);
                sent = 1'b1;
            end
        end
    end

    task automatic dispatch_random_op();
        mem_op_t o;
        logic [31:0] r;
        logic [1:0] off;
        logic accepted;
        r = rand_bits(27);
        o.is_store = r[0];
        o.size = (r[2:1] == 2'd0) ? mem_byte : (r[2:1] == 2'd1) ? mem_half : mem_word;
        o.is_signed = !r[0] && r[3];
        o.rs1 = preg_t'(r[6:4]);
        o.rs2 = r[0] ? preg_t'(r[9:7]) : '0;
        o.rd = 6'd8 + {1'b0, r[20:16]};
        off = (o.size == mem_byte) ? r[15:14] : (o.size == mem_half) ? {r[15], 1'b0} : 2'b00;
        // Immediate lands the address on the chosen word and lane
        o.imm = {26'h0, r[13:10], off} - reg_vals[r[6:4]];
        op = o;
        op_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = op_ready;
            @(posedge clk);
            #1;
        end
        op_valid = 1'b0;
        dispatched++;
        if (o.rs1 != '0) begin
            wake_tag.push_back(o.rs1);
            wake_due.push_back(cycle_cnt + 1 + int'(r[23:21]));
        end
        if (o.rs2 != '0) begin
            wake_tag.push_back(o.rs2);
            wake_due.push_back(cycle_cnt + 1 + int'(r[26:24]));
        end
    endtask

    task automatic run_batch(int n);
        for (int i = 0; i < n; i++) begin
            dispatch_random_op();
            if (rand_bits(2) == 0)
                idle_cycles(1);
        end
    endtask

    task automatic wait_for_drain();
        while (results != dispatched)
            idle_cycles(1);
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        op_valid = 1'b0;
        op = '0;
        reg_vals[0] = '0;
        for (int t = 1; t < 8; t++)
            reg_vals[t] = rand_bits(32);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(4);
        run_batch(num_ops / 2);
        wait_for_drain();
        flush = 1'b1;
        idle_cycles(1);
        flush = 1'b0;
        idle_cycles(6);
        run_batch(num_ops - num_ops / 2);
        wait_for_drain();
        idle_cycles(4);
        report = 1'b1;
        #1;
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin : watchdog
        #(timeout);
        $display("Timeout after %0d time units with %0d of %0d results seen",
                 timeout, results, num_ops);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: load_store_unit.f
+incdir+.
lsq_pkg.sv
lsq_entry_queue.sv
lsq_load_align.sv
lsq_issue_ctrl.sv
load_store_unit.sv
lsu_checker.sv
tb_load_store_unit.sv
